// File: verilog/pkt_stream_pkg.sv
`default_nettype none

package pkt_stream_pkg;

	// One beat of the 128-bit receive stream. Byte 0 sits in data[127:120].
	typedef struct packed {
		logic [127:0] data;
		logic         sop;
		logic         eop;
		logic [11:0]  tag;
	} stream_beat_t;

	// Lookup key taken from the Ethernet/IPv4 header at fixed offsets.
	typedef struct packed {
		logic [7:0]  protocol;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
	} header_key_t;

	// Word stored in the key FIFO.
	typedef struct packed {
		header_key_t key;
		logic [11:0] tag;
	} key_entry_t;

	localparam int BEAT_BYTES = 16;
	localparam int PROTO_BYTE = 23;
	localparam int DST_IP_BYTE = 30;
	localparam int DST_PORT_BYTE = 36;
	localparam int KEY_BEATS = 3;
	localparam int KEY_FIFO_DEPTH = 8;

endpackage

`default_nettype wire

// File: verilog/match_rules_pkg.sv
`default_nettype none

package match_rules_pkg;

	localparam int NUM_RULES = 8;
	localparam int RULE_IDX_W = $clog2(NUM_RULES);
	localparam int RESULT_FIFO_DEPTH = 8;

	typedef struct packed {
		logic        enable;
		logic [1:0]  dest;
		logic [7:0]  protocol;
		logic [31:0] dst_ip;
		logic [31:0] dst_ip_mask;
		logic [15:0] dst_port;
	} match_rule_t;

	typedef struct packed {
		logic [1:0]  dest;
		logic [11:0] tag;
	} match_result_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Each rule occupies 16 bytes. Addresses from RULE_SPACE upwards are unmapped.
	localparam logic [7:0] RULE_SPACE = 8'h80;
	localparam logic [3:0] CTRL_OFFSET = 4'h0;
	localparam logic [3:0] DST_IP_OFFSET = 4'h4;
	localparam logic [3:0] MASK_OFFSET = 4'h8;
	localparam logic [3:0] PORT_OFFSET = 4'hc;

endpackage

`default_nettype wire

// File: verilog/beat_counter.sv
`timescale 1ns/10ps
`default_nettype none

module beat_counter (
	input  wire logic       clock,
	input  wire logic       rst_n,
	input  wire logic       beat_fire,
	input  wire logic       eop,
	output logic      [1:0] beat_index
);

	import pkt_stream_pkg::*;

	// Index of the beat now on the bus within its packet. It stops at
	// KEY_BEATS because later beats carry nothing the key needs.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			beat_index <= '0;
		end else if (beat_fire) begin
			if (eop) begin
				beat_index <= '0;
			end else if (beat_index != 2'(KEY_BEATS)) begin
				beat_index <= beat_index + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/header_capture_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module header_capture_fsm (
	input  wire logic                        clock,
	input  wire logic                        rst_n,
	input  wire pkt_stream_pkg::stream_beat_t in_beat,
	input  wire logic                        in_valid,
	input  wire logic                        fifo_full,
	input  wire logic                  [1:0] beat_index,
	output logic                             in_ready,
	output logic                             key_push,
	output pkt_stream_pkg::key_entry_t       key_entry
);

	import pkt_stream_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		COLLECT,
		SKIP
	} state_t;

	state_t      state;
	header_key_t key_q;
	header_key_t next_key;
	logic        fire;
	logic        last_key_beat;

	// True when header byte idx lies in the beat that is now on the bus.
	function automatic logic in_this_beat(input int idx, input logic [1:0] index);
		return (idx / BEAT_BYTES) == int'(index);
	endfunction

	function automatic logic [7:0] get_byte(input logic [127:0] data, input int idx);
		return data[127 - 8 * (idx % BEAT_BYTES) -: 8];
	endfunction

	assign in_ready = !fifo_full;
	assign fire = in_valid && in_ready;
	assign last_key_beat = beat_index == 2'(KEY_BEATS - 1);

	// The key as it stands once the current beat is folded in. The push uses
	// it directly, so the bytes of the end beat need no extra cycle.
	always_comb begin
		next_key = key_q;
		if (in_this_beat(PROTO_BYTE, beat_index))
			next_key.protocol = get_byte(in_beat.data, PROTO_BYTE);
		for (int i = 0; i < 4; i++) begin
			if (in_this_beat(DST_IP_BYTE + i, beat_index))
				next_key.dst_ip[31 - 8 * i -: 8] = get_byte(in_beat.data, DST_IP_BYTE + i);
		end
		for (int i = 0; i < 2; i++) begin
			if (in_this_beat(DST_PORT_BYTE + i, beat_index))
				next_key.dst_port[15 - 8 * i -: 8] = get_byte(in_beat.data, DST_PORT_BYTE + i);
		end
	end

	always_ff @(posedge clock) begin
		if (fire)
			key_q <= next_key;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (fire) begin
			case (state)
				IDLE: if (in_beat.sop && !in_beat.eop) state <= COLLECT;
				COLLECT: begin
					if (in_beat.eop) state <= IDLE;
					else if (last_key_beat) state <= SKIP;
				end
				SKIP: if (in_beat.eop) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Packets that end before the third beat never reach SKIP or the last key beat.
	assign key_push = fire && in_beat.eop &&
		((state == COLLECT && last_key_beat) || state == SKIP);
	assign key_entry.key = next_key;
	assign key_entry.tag = in_beat.tag;

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  wire logic             clock,
	input  wire logic             rst_n,
	input  wire logic             wr_en,
	input  wire logic [WIDTH-1:0] wr_data,
	input  wire logic             rd_en,
	output logic      [WIDTH-1:0] rd_data,
	output logic                  empty,
	output logic                  full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
		end
	end

	always_ff @(posedge clock) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Show-ahead read. The head entry is on rd_data whenever the FIFO is not empty.
	assign rd_data = mem[rd_ptr];
	assign empty = count == '0;
	assign full = count == (AW+1)'(DEPTH);

endmodule

`default_nettype wire

// File: verilog/rule_table_apb.sv
`timescale 1ns/10ps
`default_nettype none

module rule_table_apb (
	input  wire logic                    clock,
	input  wire logic                    rst_n,
	input  wire match_rules_pkg::apb_req_t apb_req,
	output match_rules_pkg::apb_rsp_t    apb_rsp,
	output match_rules_pkg::match_rule_t [match_rules_pkg::NUM_RULES-1:0] rules
);

	import match_rules_pkg::*;

	logic                  access;
	logic                  in_range;
	logic [RULE_IDX_W-1:0] rule_idx;
	logic [3:0]            word_off;
	match_rule_t           sel_rule;
	logic [31:0]           rd_word;

	assign access = apb_req.psel && apb_req.penable;
	assign in_range = apb_req.paddr < RULE_SPACE;
	assign rule_idx = apb_req.paddr[4 +: RULE_IDX_W];
	assign word_off = {apb_req.paddr[3:2], 2'b00};
	assign sel_rule = rules[rule_idx];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rules <= '0;
		end else if (access && apb_req.pwrite && in_range) begin
			case (word_off)
				CTRL_OFFSET: begin
					rules[rule_idx].enable <= apb_req.pwdata[0];
					rules[rule_idx].dest <= apb_req.pwdata[2:1];
					rules[rule_idx].protocol <= apb_req.pwdata[15:8];
				end
				DST_IP_OFFSET: rules[rule_idx].dst_ip <= apb_req.pwdata;
				MASK_OFFSET: rules[rule_idx].dst_ip_mask <= apb_req.pwdata;
				default: rules[rule_idx].dst_port <= apb_req.pwdata[15:0];
			endcase
		end
	end

	always_comb begin
		case (word_off)
			CTRL_OFFSET: rd_word = {16'h0, sel_rule.protocol, 5'h0, sel_rule.dest, sel_rule.enable};
			DST_IP_OFFSET: rd_word = sel_rule.dst_ip;
			MASK_OFFSET: rd_word = sel_rule.dst_ip_mask;
			default: rd_word = {16'h0, sel_rule.dst_port};
		endcase
	end

	// No wait states. Unmapped addresses read as zero and raise the error flag.
	always_comb begin
		apb_rsp.prdata = (access && !apb_req.pwrite && in_range) ? rd_word : '0;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access && !in_range;
	end

endmodule

`default_nettype wire

// File: verilog/rule_matcher.sv
`timescale 1ns/10ps
`default_nettype none

module rule_matcher (
	input  wire logic                        clock,
	input  wire logic                        rst_n,
	input  wire pkt_stream_pkg::key_entry_t  key_entry,
	input  wire logic                        key_valid,
	input  wire match_rules_pkg::match_rule_t [match_rules_pkg::NUM_RULES-1:0] rules,
	input  wire logic                        out_ready,
	output logic                             key_ready,
	output match_rules_pkg::match_result_t   result,
	output logic                             result_valid
);

	import pkt_stream_pkg::*;
	import match_rules_pkg::*;

	header_key_t key;
	logic        any_hit;
	logic [1:0]  hit_dest;
	logic        take;

	assign key = key_entry.key;

	// Walk from the top index down so that the lowest hitting rule wins.
	always_comb begin
		any_hit = 1'b0;
		hit_dest = '0;
		for (int i = NUM_RULES - 1; i >= 0; i--) begin
			if (rules[i].enable &&
				rules[i].protocol == key.protocol &&
				(rules[i].dst_ip & rules[i].dst_ip_mask) == (key.dst_ip & rules[i].dst_ip_mask) &&
				(rules[i].dst_port == '0 || rules[i].dst_port == key.dst_port)) begin
				any_hit = 1'b1;
				hit_dest = rules[i].dest;
			end
		end
	end

	// The output register takes a new key only when it is empty or being drained.
	assign key_ready = !result_valid || out_ready;
	assign take = key_valid && key_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else if (take) begin
			// A key that hits nothing is consumed here and leaves no result.
			result_valid <= any_hit;
		end else if (out_ready) begin
			result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			result.dest <= hit_dest;
			result.tag <= key_entry.tag;
		end
	end

endmodule

`default_nettype wire

// File: verilog/header_match_block.sv
`timescale 1ns/10ps
`default_nettype none

module header_match_block (
	input  wire logic                          clock,
	input  wire logic                          rst_n,
	input  wire pkt_stream_pkg::stream_beat_t  in_beat,
	input  wire logic                          in_valid,
	output logic                               in_ready,
	input  wire match_rules_pkg::apb_req_t     apb_req,
	output match_rules_pkg::apb_rsp_t          apb_rsp,
	output match_rules_pkg::match_result_t     result,
	output logic                               result_valid,
	input  wire logic                          result_ready
);

	import pkt_stream_pkg::*;
	import match_rules_pkg::*;

	logic          beat_fire;
	logic [1:0]    beat_index;
	logic          key_push;
	key_entry_t    key_wr;
	key_entry_t    key_rd;
	logic          key_empty;
	logic          key_full;
	logic          key_ready;
	match_rule_t [NUM_RULES-1:0] rules;
	match_result_t m_result;
	logic          m_valid;
	logic          res_full;
	logic          res_empty;

	assign beat_fire = in_valid && in_ready;
	assign result_valid = !res_empty;

	beat_counter u_beat_counter (
		.clock, .rst_n, .beat_fire, .eop(in_beat.eop), .beat_index
	);

	header_capture_fsm u_capture (
		.clock, .rst_n, .in_beat, .in_valid, .fifo_full(key_full), .beat_index,
		.in_ready, .key_push, .key_entry(key_wr)
	);

	sync_fifo #(.WIDTH($bits(key_entry_t)), .DEPTH(KEY_FIFO_DEPTH)) u_key_fifo (
		.clock, .rst_n, .wr_en(key_push), .wr_data(key_wr),
		.rd_en(key_ready && !key_empty), .rd_data(key_rd), .empty(key_empty), .full(key_full)
	);

	rule_table_apb u_rule_table (
		.clock, .rst_n, .apb_req, .apb_rsp, .rules
	);

	// The matcher stalls as soon as the result FIFO is full.
	rule_matcher u_matcher (
		.clock, .rst_n, .key_entry(key_rd), .key_valid(!key_empty), .rules,
		.out_ready(!res_full), .key_ready, .result(m_result), .result_valid(m_valid)
	);

	sync_fifo #(.WIDTH($bits(match_result_t)), .DEPTH(RESULT_FIFO_DEPTH)) u_result_fifo (
		.clock, .rst_n, .wr_en(m_valid && !res_full), .wr_data(m_result),
		.rd_en(result_valid && result_ready), .rd_data(result), .empty(res_empty), .full(res_full)
	);

endmodule

`default_nettype wire

// File: verification/header_match_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

module header_match_block_tb;

	import pkt_stream_pkg::*;
	import match_rules_pkg::*;

	localparam int TIMEOUT = 2000;

	logic          clock;
	logic          rst_n;
	stream_beat_t  in_beat;
	logic          in_valid;
	logic          in_ready;
	apb_req_t      apb_req;
	apb_rsp_t      apb_rsp;
	match_result_t result;
	logic          result_valid;
	logic          result_ready;

	integer        seed;
	int            fail_count;
	int            timeout_count;
	logic          random_ready;
	logic          stall_seen;
	match_rule_t   rule_model [NUM_RULES];
	match_result_t expected [$];

	header_match_block DUT (
		.clock(clock), .rst_n(rst_n), .in_beat(in_beat), .in_valid(in_valid),
		.in_ready(in_ready), .apb_req(apb_req), .apb_rsp(apb_rsp), .result(result),
		.result_valid(result_valid), .result_ready(result_ready)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_result(input string name, input match_result_t exp,
			input match_result_t act);
		if (exp !== act) begin
			fail_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_apb(input string name, input apb_rsp_t exp, input apb_rsp_t act);
		if (exp !== act) begin
			fail_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			fail_count++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic apb_rsp_t make_rsp(input logic [31:0] data, input logic err);
		apb_rsp_t r;
		r.prdata = data;
		r.pready = 1'b1;
		r.pslverr = err;
		return r;
	endfunction

	// Register word of a rule as the address map lays it out.
	function automatic logic [31:0] rule_word(input match_rule_t r, input int off);
		logic [31:0] w;
		w = '0;
		case (off)
			0: begin
				w[0] = r.enable;
				w[2:1] = r.dest;
				w[15:8] = r.protocol;
			end
			1: w = r.dst_ip;
			2: w = r.dst_ip_mask;
			default: w[15:0] = r.dst_port;
		endcase
		return w;
	endfunction

	// Reference model. Scans from rule 0 and stops at the first hit.
	function automatic logic model_hit(input header_key_t key, output logic [1:0] dest);
		dest = 2'd0;
		for (int i = 0; i < NUM_RULES; i++) begin
			if (rule_model[i].enable && rule_model[i].protocol == key.protocol &&
				((rule_model[i].dst_ip ^ key.dst_ip) & rule_model[i].dst_ip_mask) == 0 &&
				(rule_model[i].dst_port == 0 || rule_model[i].dst_port == key.dst_port)) begin
				dest = rule_model[i].dest;
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output apb_rsp_t rsp);
		int waited;
		waited = 0;
		@(negedge clock);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clock);
		apb_req.penable = 1'b1;
		#1;
		while (!apb_rsp.pready && waited < TIMEOUT) begin
			@(negedge clock);
			#1;
			waited++;
		end
		if (!apb_rsp.pready) begin
			timeout_count++;
			$display("APB access to address %h never saw pready", addr);
		end
		rsp = apb_rsp;
		@(negedge clock);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic write_rule(input int idx, input match_rule_t r);
		apb_rsp_t rsp;
		for (int off = 0; off < 4; off++) begin
			apb_access(1'b1, 8'(16 * idx + 4 * off), rule_word(r, off), rsp);
			check_flag("rule_write_err", 1'b0, rsp.pslverr);
		end
		rule_model[idx] = r;
	endtask

	task automatic read_all_rules(input string name);
		apb_rsp_t rsp;
		for (int i = 0; i < NUM_RULES; i++) begin
			for (int off = 0; off < 4; off++) begin
				apb_access(1'b0, 8'(16 * i + 4 * off), 32'h0, rsp);
				check_apb(name, make_rsp(rule_word(rule_model[i], off), 1'b0), rsp);
			end
		end
	endtask

	// Two address bases and a small mask set make rules overlap often.
	task automatic make_rule(input int idx, output match_rule_t r);
		r.enable = (idx != 5);
		r.dest = 2'($random(seed));
		r.protocol = ($random(seed) & 1) ? 8'd6 : 8'd17;
		r.dst_ip = {8'd10, 8'(idx % 2), 16'($random(seed))};
		case ($random(seed) & 3)
			0: r.dst_ip_mask = 32'hffff_ffff;
			1: r.dst_ip_mask = 32'hffff_ff00;
			2: r.dst_ip_mask = 32'hffff_0000;
			default: r.dst_ip_mask = 32'h0000_0000;
		endcase
		r.dst_port = (($random(seed) & 3) == 0) ? 16'h0 : 16'($random(seed));
	endtask

	task automatic make_key(output header_key_t key);
		match_rule_t r;
		r = rule_model[$unsigned($random(seed)) % NUM_RULES];
		key.protocol = (($random(seed) & 3) != 0) ? r.protocol : 8'($random(seed));
		key.dst_ip = (($random(seed) & 3) != 0) ?
			((r.dst_ip & r.dst_ip_mask) | (32'($random(seed)) & ~r.dst_ip_mask)) :
			32'($random(seed));
		key.dst_port = (($random(seed) & 3) != 0) ? r.dst_port : 16'($random(seed));
	endtask

	task automatic send_packet(input int nbeats);
		logic [7:0]    bytes [96];
		stream_beat_t  beat;
		header_key_t   key;
		logic [11:0]   tag;
		logic [1:0]    dest;
		match_result_t exp;
		int            waited;
		make_key(key);
		tag = 12'($random(seed));
		for (int i = 0; i < 96; i++)
			bytes[i] = 8'($random(seed));
		bytes[PROTO_BYTE] = key.protocol;
		for (int i = 0; i < 4; i++)
			bytes[DST_IP_BYTE + i] = key.dst_ip[31 - 8 * i -: 8];
		for (int i = 0; i < 2; i++)
			bytes[DST_PORT_BYTE + i] = key.dst_port[15 - 8 * i -: 8];
		for (int b = 0; b < nbeats; b++) begin
			@(negedge clock);
			if (($random(seed) & 3) == 0) begin
				in_valid = 1'b0;
				@(negedge clock);
			end
			for (int j = 0; j < 16; j++)
				beat.data[127 - 8 * j -: 8] = bytes[16 * b + j];
			beat.sop = (b == 0);
			beat.eop = (b == nbeats - 1);
			beat.tag = beat.eop ? tag : 12'($random(seed));
			if (beat.eop && nbeats >= KEY_BEATS && model_hit(key, dest)) begin
				exp.dest = dest;
				exp.tag = tag;
				expected.push_back(exp);
			end
			in_beat = beat;
			in_valid = 1'b1;
			waited = 0;
			// in_ready only moves on a rising edge, so the low phase shows the next transfer.
			while (!in_ready && waited < TIMEOUT) begin
				stall_seen = 1'b1;
				@(negedge clock);
				waited++;
			end
			if (!in_ready) begin
				timeout_count++;
				$display("Stream input stayed stalled with in_ready low");
			end
		end
		@(negedge clock);
		in_valid = 1'b0;
	endtask

	task automatic wait_drain(input string name);
		int waited;
		waited = 0;
		while (expected.size() != 0 && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (expected.size() != 0) begin
			timeout_count++;
			$display("In %s, %0d expected results never came out", name, expected.size());
		end
		repeat (10) @(negedge clock);
		#1;
		check_flag({name, "_idle_valid"}, 1'b0, result_valid);
		check_flag({name, "_idle_ready"}, 1'b1, in_ready);
	endtask

	// Result sink. A transfer seen in the low phase completes on the next rising edge.
	initial begin
		forever begin
			@(negedge clock);
			result_ready = random_ready ? (($random(seed) & 31) == 0) : 1'b1;
			#1;
			if (result_valid && result_ready) begin
				if (expected.size() == 0) begin
					fail_count++;
					$display("A result with tag %h came out while none was expected", result.tag);
				end else begin
					check_result("stream_result", expected.pop_front(), result);
				end
			end
		end
	end

	initial begin
		match_rule_t r;
		apb_rsp_t    rsp;
		logic [7:0]  bad_addr;
		seed = 32'h324a_387a;
		fail_count = 0;
		timeout_count = 0;
		random_ready = 1'b0;
		stall_seen = 1'b0;
		rst_n = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		apb_req = '0;
		result_ready = 1'b0;
		for (int i = 0; i < NUM_RULES; i++)
			rule_model[i] = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		#1;
		check_flag("reset_result_valid", 1'b0, result_valid);
		check_flag("reset_in_ready", 1'b1, in_ready);
		read_all_rules("reset_read");

		for (int i = 0; i < NUM_RULES; i++) begin
			make_rule(i, r);
			write_rule(i, r);
		end
		read_all_rules("rule_readback");
		bad_addr = RULE_SPACE | 8'($random(seed) & 8'h7c);
		apb_access(1'b1, bad_addr, 32'($random(seed)), rsp);
		check_flag("bad_write_err", 1'b1, rsp.pslverr);
		apb_access(1'b0, bad_addr, 32'h0, rsp);
		check_apb("bad_read", make_rsp(32'h0, 1'b1), rsp);
		read_all_rules("rule_after_bad");

		// Steady sink first, then a sink that stalls often enough to fill both FIFOs.
		for (int n = 0; n < 80; n++)
			send_packet(1 + $unsigned($random(seed)) % 6);
		wait_drain("steady_sink");
		random_ready = 1'b1;
		for (int n = 0; n < 150; n++)
			send_packet(1 + $unsigned($random(seed)) % 6);
		random_ready = 1'b0;
		wait_drain("stalling_sink");
		check_flag("in_ready_dropped", 1'b1, stall_seen);

		$display("errors: %0d mismatches, %0d timeouts", fail_count, timeout_count);
		if (fail_count == 0 && timeout_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: header_match_block.f
verilog/pkt_stream_pkg.sv
verilog/match_rules_pkg.sv
verilog/beat_counter.sv
verilog/header_capture_fsm.sv
verilog/sync_fifo.sv
verilog/rule_table_apb.sv
verilog/rule_matcher.sv
verilog/header_match_block.sv
verification/header_match_block_tb.sv

// File: Bender.yml
package:
  name: header_match_block

sources:
  - verilog/pkt_stream_pkg.sv
  - verilog/match_rules_pkg.sv
  - verilog/beat_counter.sv
  - verilog/header_capture_fsm.sv
  - verilog/sync_fifo.sv
  - verilog/rule_table_apb.sv
  - verilog/rule_matcher.sv
  - verilog/header_match_block.sv
  - target: test
    files:
      - verification/header_match_block_tb.sv
